//--- hdl/epoch_if.sv
/*
 * Link between the epoch timer and the event classifier.
 * The timer owns the decay and refractory flags, the classifier owns a_end.
 */
`timescale 1ns/1ps
`default_nettype none

interface epoch_if
    import nm_timing_pkg::*;
(
    input logic clk,
    input logic reset
);

    logic decay_expired;    // one-cycle pulse, quiet period is over
    logic refractory_over;  // level, B may be entered again
    logic a_end;            // one-cycle pulse when class A is left

    modport timer (output decay_expired, output refractory_over, input a_end);
    modport classifier (input refractory_over, output a_end);

    // a tick needs at least one cycle, so the window lasts at least this many cycles
    refractory_hold: assert property (@(posedge clk) disable iff (reset)
        a_end |=> !refractory_over [*REFRACTORY_SAMPLES])
        else $error("refractory window shorter than REFRACTORY_SAMPLES");

endinterface

`default_nettype wire

//--- hdl/epoch_timer.sv
/*
 * Counts sample ticks since the last detection and since the last A section ended.
 * Drives the decay pulse and the refractory level on the epoch interface.
 */
`timescale 1ns/1ps
`default_nettype none

module epoch_timer
    import nm_timing_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   sample_valid,
    input  logic   detection,
    epoch_if.timer ep
);

    logic [CNT_W-1:0] quiet_cnt;
    logic [CNT_W-1:0] refr_cnt;

    // fires on the tick that brings the quiet count to DECAY_SAMPLES
    assign ep.decay_expired = sample_valid && !detection &&
                              (quiet_cnt == CNT_W'(DECAY_SAMPLES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            quiet_cnt <= CNT_W'(DECAY_SAMPLES);  // starts expired, level is already zero
        end else if (detection) begin
            quiet_cnt <= '0;
        end else if (sample_valid && quiet_cnt != CNT_W'(DECAY_SAMPLES)) begin
            quiet_cnt <= quiet_cnt + 1'b1;  // holds once the decay has fired
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            refr_cnt           <= '0;
            ep.refractory_over <= 1'b1;
        end else if (ep.a_end) begin
            refr_cnt           <= '0;
            ep.refractory_over <= 1'b0;
        end else if (sample_valid && !ep.refractory_over) begin
            refr_cnt <= refr_cnt + 1'b1;
            if (refr_cnt == CNT_W'(REFRACTORY_SAMPLES - 1)) begin
                ep.refractory_over <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/event_classifier.sv
/*
 * Class FSM over the excitability level: C background, B elevated, A seizure-like.
 * A needs CONFIRM_A consecutive high ticks, B entry from C waits for the
 * refractory period after an A section.
 */
`timescale 1ns/1ps
`default_nettype none

module event_classifier
    import nm_event_pkg::*;
    import nm_timing_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                sample_valid,
    input  logic [EXC_W-1:0]    excitability,
    input  logic [THRESH_W-1:0] class_a_thresh,
    input  logic [THRESH_W-1:0] class_b_thresh,
    epoch_if.classifier         ep,
    output logic [EVENT_W-1:0]  event_class
);

    logic [EXC_W-1:0]   a_level;
    logic [EXC_W-1:0]   b_level;
    logic               high;
    logic               mid;
    logic               confirmed;
    logic [CNT_W-1:0]   confirm_cnt;
    logic [EVENT_W-1:0] next_class;

    assign a_level   = EXC_W'(class_a_thresh) * EXC_STEP;  // fits in EXC_W up to 15 steps
    assign b_level   = EXC_W'(class_b_thresh) * EXC_STEP;
    assign high      = excitability >= a_level;
    assign mid       = excitability >= b_level;
    assign confirmed = high && (confirm_cnt == CNT_W'(CONFIRM_A));

    always_ff @(posedge clk) begin
        if (reset || !high) begin
            confirm_cnt <= '0;
        end else if (sample_valid && !confirmed) begin
            confirm_cnt <= confirm_cnt + 1'b1;  // saturates at CONFIRM_A
        end
    end

    always_comb begin
        next_class = event_class;
        case (event_class)
            EVENT_C: begin
                if (confirmed) next_class = EVENT_A;
                else if (mid && ep.refractory_over) next_class = EVENT_B;
            end
            EVENT_B: begin
                if (confirmed) next_class = EVENT_A;
                else if (!mid) next_class = EVENT_C;
            end
            EVENT_A: begin
                if (!high) next_class = mid ? EVENT_B : EVENT_C;
            end
            default: next_class = EVENT_C;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            event_class <= EVENT_C;
            ep.a_end    <= 1'b0;
        end else begin
            event_class <= next_class;
            ep.a_end    <= (event_class == EVENT_A) && !high;  // same edge as the exit
        end
    end

    class_code_valid: assert property (@(posedge clk) disable iff (reset)
        event_class != EVENT_W'(3))
        else $error("class code 3 is unused");

    a_end_from_a: assert property (@(posedge clk) disable iff (reset)
        ep.a_end |-> $past(event_class) == EVENT_A && event_class != EVENT_A)
        else $error("a_end without the class just leaving A");

endmodule

`default_nettype wire

//--- hdl/event_reporter.sv
/*
 * Sends class changes to the host over a four-phase req/ack handshake.
 * Changes seen while a handshake is busy are not queued, only the latest
 * class is compared with the last reported one.
 */
`timescale 1ns/1ps
`default_nettype none

module event_reporter
    import nm_event_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic [EVENT_W-1:0] event_class,
    input  logic               report_ack,
    output logic               report_req,
    output logic [EVENT_W-1:0] report_class
);

    logic [REP_W-1:0] state;

    assign report_req = (state == REP_REQ);

    // report_class doubles as the last reported class
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= REP_IDLE;
            report_class <= EVENT_C;
        end else begin
            case (state)
                REP_IDLE: begin
                    if (event_class != report_class && !report_ack) begin
                        state        <= REP_REQ;
                        report_class <= event_class;
                    end
                end
                REP_REQ: if (report_ack) state <= REP_RELEASE;
                REP_RELEASE: if (!report_ack) state <= REP_IDLE;
                default: state <= REP_IDLE;
            endcase
        end
    end

    class_stable: assert property (@(posedge clk) disable iff (reset)
        $past(report_req || report_ack) |-> $stable(report_class))
        else $error("report_class changed while req or ack was high");

    no_req_on_ack: assert property (@(posedge clk) disable iff (reset)
        $rose(report_req) |-> !report_ack)
        else $error("req rose while the host still held ack");

endmodule

`default_nettype wire

//--- hdl/excitability_accum.sv
/*
 * Saturating excitability level. Each detection adds one step and
 * the level clears at once when the timer signals the end of the quiet period.
 */
`timescale 1ns/1ps
`default_nettype none

module excitability_accum
    import nm_timing_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             detection,
    input  logic             decay_expired,
    output logic [EXC_W-1:0] excitability
);

    always_ff @(posedge clk) begin
        if (reset) begin
            excitability <= '0;
        end else if (decay_expired) begin
            excitability <= '0;
        end else if (detection) begin
            if (excitability >= EXC_SAT - EXC_STEP) begin
                excitability <= EXC_SAT;  // clamp at ten steps
            end else begin
                excitability <= excitability + EXC_STEP;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/neural_monitor_top.sv
/*
 * Top level of the event classification front end.
 * Detector, accumulator, epoch timer, classifier and reporter in a chain,
 * with the host side on plain ports.
 */
`timescale 1ns/1ps
`default_nettype none

module neural_monitor_top
    import nm_event_pkg::*;
    import nm_timing_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       sample_valid,
    input  logic signed [SAMPLE_W-1:0] sample,
    input  logic [SAMPLE_W-1:0]        spike_thresh,
    input  logic [THRESH_W-1:0]        class_a_thresh,
    input  logic [THRESH_W-1:0]        class_b_thresh,
    input  logic                       report_ack,
    output logic                       report_req,
    output logic [EVENT_W-1:0]         report_class
);

    logic               detection;
    logic [EXC_W-1:0]   excitability;
    logic [EVENT_W-1:0] event_class;

    epoch_if u_epoch_if (.clk(clk), .reset(reset));

    spike_detector u_spike_detector (
        .clk(clk), .reset(reset), .sample_valid(sample_valid), .sample(sample),
        .spike_thresh(spike_thresh), .detection(detection)
    );

    excitability_accum u_excitability_accum (
        .clk(clk), .reset(reset), .detection(detection),
        .decay_expired(u_epoch_if.decay_expired), .excitability(excitability)
    );

    epoch_timer u_epoch_timer (
        .clk(clk), .reset(reset), .sample_valid(sample_valid), .detection(detection),
        .ep(u_epoch_if.timer)
    );

    event_classifier u_event_classifier (
        .clk(clk), .reset(reset), .sample_valid(sample_valid), .excitability(excitability),
        .class_a_thresh(class_a_thresh), .class_b_thresh(class_b_thresh),
        .ep(u_epoch_if.classifier), .event_class(event_class)
    );

    event_reporter u_event_reporter (
        .clk(clk), .reset(reset), .event_class(event_class), .report_ack(report_ack),
        .report_req(report_req), .report_class(report_class)
    );

endmodule

`default_nettype wire

//--- hdl/nm_event_pkg.sv
/*
 * Event class codes, sample widths and report FSM codes shared by the
 * classifier, the reporter and the testbench.
 */
`default_nettype none

package nm_event_pkg;

    localparam int SAMPLE_W = 12;                        // signed neural sample
    localparam int THRESH_W = 4;                         // class thresholds in detection counts

    localparam int EVENT_W = 2;
    localparam logic [EVENT_W-1:0] EVENT_C = 2'd0;       // background
    localparam logic [EVENT_W-1:0] EVENT_B = 2'd1;       // elevated
    localparam logic [EVENT_W-1:0] EVENT_A = 2'd2;       // seizure-like

    localparam int REP_W = 2;
    localparam logic [REP_W-1:0] REP_IDLE    = 2'd0;
    localparam logic [REP_W-1:0] REP_REQ     = 2'd1;     // req high, waiting for ack
    localparam logic [REP_W-1:0] REP_RELEASE = 2'd2;     // req low, waiting for ack to drop

endpackage

`default_nettype wire

//--- hdl/nm_timing_pkg.sv
/*
 * Time constants and excitability scaling for the neural monitor front end.
 * Periods are counted in sample ticks and are scaled down for simulation.
 */
`default_nettype none

package nm_timing_pkg;

    localparam int EXC_W = 8;                            // excitability level width
    localparam logic [EXC_W-1:0] EXC_STEP = 8'd16;       // added for each detection
    localparam logic [EXC_W-1:0] EXC_SAT  = 8'd160;      // ten steps, the level never goes higher

    localparam int CNT_W = 8;                            // width of all tick counters
    localparam int DECAY_SAMPLES      = 64;              // quiet ticks before the level clears
    localparam int REFRACTORY_SAMPLES = 96;              // ticks after an A section with no B entry
    localparam int CONFIRM_A          = 4;               // high ticks needed before class A

endpackage

`default_nettype wire

//--- hdl/spike_detector.sv
/*
 * Threshold crossing detector on the sample magnitude.
 * Disarms after each detection and rearms below half the threshold,
 * so one spike gives exactly one detection pulse.
 */
`timescale 1ns/1ps
`default_nettype none

module spike_detector
    import nm_event_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       sample_valid,
    input  logic signed [SAMPLE_W-1:0] sample,
    input  logic [SAMPLE_W-1:0]        spike_thresh,
    output logic                       detection
);

    logic [SAMPLE_W-1:0] magnitude;
    logic                armed;

    // -2048 maps to 2048, which still fits as unsigned
    assign magnitude = sample[SAMPLE_W-1] ? $unsigned(-sample) : $unsigned(sample);

    always_ff @(posedge clk) begin
        if (reset) begin
            armed     <= 1'b1;
            detection <= 1'b0;
        end else begin
            detection <= 1'b0;
            if (sample_valid) begin
                if (armed && magnitude >= spike_thresh) begin
                    detection <= 1'b1;
                    armed     <= 1'b0;
                end else if (!armed && magnitude < (spike_thresh >> 1)) begin
                    armed <= 1'b1;  // hysteresis at half threshold
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Builds the neural monitor testbench with Verilator and runs it.
# The exit status is non-zero unless the simulation log holds the pass line.
verilator --binary --timing --assert -f verilog.f --top-module neural_monitor_tb \
    -o neural_monitor_sim &&
./obj_dir/neural_monitor_sim | tee sim.log &&
grep -qx "Test passed" sim.log ||
{ echo "simulation did not pass, see sim.log"; exit 1; }

//--- tb/neural_monitor_tb.sv
/*
 * Testbench for the neural monitor front end. Replays a table of spike bursts
 * with LFSR noise in between, answers the report handshake with a per-row ack
 * delay and lets report_checker compare the reported classes.
 */
`timescale 1ns/1ps
`default_nettype none

module neural_monitor_tb
    import nm_event_pkg::*;
    import nm_timing_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int QUIET_CYCLES = DECAY_SAMPLES + REFRACTORY_SAMPLES + 140;
    localparam int IDLE_LIMIT   = 1000;
    localparam logic signed [SAMPLE_W-1:0] SPIKE_AMP = 12'sd1500;

    typedef struct packed {
        logic [63:0]             name;       // eight characters
        logic [THRESH_W-1:0]     a_thresh;
        logic [THRESH_W-1:0]     b_thresh;
        logic [7:0]              n_spikes;
        logic [7:0]              spacing;    // cycles from one spike to the next
        logic [7:0]              gap;        // noise cycles before the second burst
        logic [7:0]              n_second;
        logic [7:0]              ack_delay;
        logic [1:0]              n_exp;
        logic [2:0][EVENT_W-1:0] exp;        // expected reports in order, exp[0] first
    } row_t;

    logic                       clk;
    logic                       reset;
    logic                       sample_valid;
    logic signed [SAMPLE_W-1:0] sample;
    logic [SAMPLE_W-1:0]        spike_thresh;
    logic [THRESH_W-1:0]        class_a_thresh;
    logic [THRESH_W-1:0]        class_b_thresh;
    logic                       report_ack;
    logic                       report_req;
    logic [EVENT_W-1:0]         report_class;
    logic                       exp_push;
    logic [EVENT_W-1:0]         exp_class;
    logic                       row_end;
    logic [63:0]                test_name;
    logic [15:0]                lfsr_state;
    int                         check_errors;
    int                         tb_errors;
    int                         total_errors;
    int                         ack_delay;
    int                         ack_wait;
    int                         limit_cycles;
    row_t                       rows[$];

    neural_monitor_top u_neural_monitor_top (
        .clk(clk), .reset(reset), .sample_valid(sample_valid), .sample(sample),
        .spike_thresh(spike_thresh), .class_a_thresh(class_a_thresh),
        .class_b_thresh(class_b_thresh), .report_ack(report_ack),
        .report_req(report_req), .report_class(report_class)
    );

    report_checker u_report_checker (
        .clk(clk), .reset(reset), .report_req(report_req), .report_class(report_class),
        .exp_push(exp_push), .exp_class(exp_class), .row_end(row_end),
        .test_name(test_name), .error_count(check_errors)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^16 + x^14 + x^13 + x^11, one step per bit taken
    function automatic logic take_bit();
        lfsr_state = {lfsr_state[14:0],
                      lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
        return lfsr_state[0];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // magnitude stays below 256, well under half of spike_thresh
    task automatic drive_noise();
        logic [8:0]                 bits;
        logic signed [SAMPLE_W-1:0] mag;
        for (int i = 0; i < 9; i++) bits[i] = take_bit();
        mag    = {4'b0, bits[7:0]};
        sample = bits[8] ? -mag : mag;
        next_cycle();
    endtask

    task automatic drive_burst(input logic [7:0] n, input logic [7:0] spacing);
        for (int k = 0; k < int'(n); k++) begin
            sample = take_bit() ? -SPIKE_AMP : SPIKE_AMP;
            next_cycle();
            repeat (spacing - 8'd1) drive_noise();
        end
    endtask

    task automatic add_row(input logic [63:0] name, input int a, input int b, input int n,
                           input int spacing, input int gap, input int n2, input int ack,
                           input int n_exp, input logic [EVENT_W-1:0] e0,
                           input logic [EVENT_W-1:0] e1, input logic [EVENT_W-1:0] e2);
        row_t r;
        r.name      = name;
        r.a_thresh  = THRESH_W'(a);
        r.b_thresh  = THRESH_W'(b);
        r.n_spikes  = 8'(n);
        r.spacing   = 8'(spacing);
        r.gap       = 8'(gap);
        r.n_second  = 8'(n2);
        r.ack_delay = 8'(ack);
        r.n_exp     = 2'(n_exp);
        r.exp       = {e2, e1, e0};
        rows.push_back(r);
    endtask

    function automatic int row_cycles(input row_t r);
        return int'(r.n_exp) + (int'(r.n_spikes) + int'(r.n_second)) * int'(r.spacing) +
               int'(r.gap) + QUIET_CYCLES + 1;
    endfunction

    task automatic run_row(input row_t r);
        int waited;
        test_name      = r.name;
        class_a_thresh = r.a_thresh;
        class_b_thresh = r.b_thresh;
        ack_delay      = int'(r.ack_delay);
        for (int i = 0; i < int'(r.n_exp); i++) begin
            exp_push  = 1'b1;
            exp_class = r.exp[i];
            drive_noise();
        end
        exp_push = 1'b0;
        drive_burst(r.n_spikes, r.spacing);
        repeat (r.gap) drive_noise();
        drive_burst(r.n_second, r.spacing);
        repeat (QUIET_CYCLES) drive_noise();  // decay and refractory both run out
        waited = 0;
        while ((report_req || report_ack) && waited < IDLE_LIMIT) begin
            drive_noise();
            waited++;
        end
        if (waited == IDLE_LIMIT) begin
            $display("test %0s: report handshake still busy after the quiet period", r.name);
            tb_errors++;
        end
        row_end = 1'b1;
        drive_noise();
        row_end = 1'b0;
    endtask

    // host side, ack follows req after the row's delay and drops once req is gone
    initial begin
        report_ack = 1'b0;
        ack_wait   = 0;
        forever begin
            next_cycle();
            if (report_ack) begin
                if (!report_req) report_ack = 1'b0;
            end else if (report_req) begin
                ack_wait++;
                if (ack_wait >= ack_delay) begin
                    report_ack = 1'b1;
                    ack_wait   = 0;
                end
            end
        end
    end

    initial begin
        wait (limit_cycles != 0);
        #(limit_cycles * CLK_PERIOD * 2);
        $display("watchdog expired before the stimulus table was done");
        $display("Test failed");
        $finish;
    end

    initial begin
        reset          = 1'b1;
        sample_valid   = 1'b0;
        sample         = '0;
        spike_thresh   = 12'd800;
        class_a_thresh = 4'd4;
        class_b_thresh = 4'd2;
        exp_push       = 1'b0;
        exp_class      = EVENT_C;
        row_end        = 1'b0;
        test_name      = '0;
        tb_errors      = 0;
        ack_delay      = 1;
        lfsr_state     = 16'd53289;

        //       name        a  b  n  sp gap n2 ack exp reports
        add_row("no_event", 4, 2, 1, 8, 0,  0, 2,   0, EVENT_C, EVENT_C, EVENT_C);
        add_row("b_report", 4, 2, 2, 8, 0,  0, 2,   2, EVENT_B, EVENT_C, EVENT_C);
        add_row("a_report", 4, 2, 4, 8, 0,  0, 2,   3, EVENT_B, EVENT_A, EVENT_C);
        add_row("b_thresh", 4, 1, 1, 8, 0,  0, 2,   2, EVENT_B, EVENT_C, EVENT_C);
        add_row("a_thresh", 2, 1, 2, 8, 0,  0, 2,   3, EVENT_B, EVENT_A, EVENT_C);
        add_row("refr_win", 3, 2, 3, 8, 64, 2, 2,   3, EVENT_B, EVENT_A, EVENT_C);
        add_row("slow_ack", 3, 2, 3, 8, 0,  0, 40,  3, EVENT_B, EVENT_A, EVENT_C);
        add_row("a_missed", 3, 2, 3, 8, 0,  0, 120, 2, EVENT_B, EVENT_C, EVENT_C);

        limit_cycles = RESET_CYCLES;
        foreach (rows[i]) limit_cycles += row_cycles(rows[i]);

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset        = 1'b0;
        sample_valid = 1'b1;
        foreach (rows[i]) run_row(rows[i]);

        total_errors = check_errors + tb_errors;
        $display("errors: %0d (checker %0d, testbench %0d)",
                 total_errors, check_errors, tb_errors);
        if (total_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/report_checker.sv
/*
 * Watches the req/ack report port of the DUT. Expected classes are pushed
 * by the testbench before each row, one is popped at every req rise, and
 * a row_end pulse flags expected reports that never came.
 */
`timescale 1ns/1ps
`default_nettype none

module report_checker
    import nm_event_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               report_req,
    input  logic [EVENT_W-1:0] report_class,
    input  logic               exp_push,
    input  logic [EVENT_W-1:0] exp_class,
    input  logic               row_end,
    input  logic [63:0]        test_name,
    output int                 error_count
);

    logic [EVENT_W-1:0] expected[$];
    logic [EVENT_W-1:0] exp_now;
    logic               req_q;

    always @(posedge clk) begin
        if (reset) begin
            req_q       <= 1'b0;
            error_count = 0;
        end else begin
            req_q <= report_req;
            if (exp_push) expected.push_back(exp_class);
            if (report_req && !req_q) begin
                if (expected.size() == 0) begin
                    $display("test %0s: unexpected report of class %0d", test_name, report_class);
                    error_count = error_count + 1;
                end else begin
                    exp_now = expected.pop_front();
                    if (report_class != exp_now) begin
                        $display("ERROR test %0s: expected class %0d, actual %0d",
                                 test_name, exp_now, report_class);
                        error_count = error_count + 1;
                    end
                end
            end
            if (row_end && expected.size() != 0) begin
                $display("test %0s: %0d expected reports were never made",
                         test_name, expected.size());
                error_count = error_count + 1;
                expected.delete();
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
hdl/nm_timing_pkg.sv
hdl/nm_event_pkg.sv
hdl/epoch_if.sv
hdl/spike_detector.sv
hdl/excitability_accum.sv
hdl/epoch_timer.sv
hdl/event_classifier.sv
hdl/event_reporter.sv
hdl/neural_monitor_top.sv
tb/report_checker.sv
tb/neural_monitor_tb.sv
